// ==== rv_pkg.sv ====
// ----------------------------------------
// rv32i core types: opcode and alu enums,
// instruction formats and stage structs
// ----------------------------------------
package rv_pkg;

    parameter int XLEN = 32;
    parameter logic [XLEN-1:0] RESET_PC = '0; // link pc seen right after reset

    typedef enum logic [6:0] {
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        ARITH     = 7'b0110011,
        ARITH_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } opcode_branch_t;

    typedef enum logic [2:0] {
        ADD_L  = 3'b000,
        SLL_L  = 3'b001,
        SLT_L  = 3'b010,
        SLTU_L = 3'b011,
        XOR_L  = 3'b100,
        SRA_L  = 3'b101, // srl and sra share func3
        OR_L   = 3'b110,
        AND_L  = 3'b111
    } opcode_alu_t;

    // {instr[30], func3}, plus branch-only codes
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SEQ    = 4'b1001, // beq
        ALU_SLT_N  = 4'b1010, // bge, slt with inverted branch sense
        ALU_SLTU_N = 4'b1011, // bgeu
        ALU_SRA    = 4'b1101
    } alu_oper_t;

    typedef enum logic [1:0] {OPER1_RS1, OPER1_PC, OPER1_ZERO} alu_oper1_src_t;
    typedef enum logic [1:0] {OPER2_RS2, OPER2_IMM, OPER2_PC_INC} alu_oper2_src_t;
    typedef enum logic [1:0] {BNJ_NO, BNJ_JAL, BNJ_JALR, BNJ_BRANCH} bnj_oper_t;

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
        logic [31:0] raw;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        alu_oper_t       alu_oper;
        alu_oper1_src_t  alu_oper1_src;
        alu_oper2_src_t  alu_oper2_src;
        bnj_oper_t       bnj_oper;
        logic            write_rd;
        logic [4:0]      rd_addr;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            write_rd;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] rd_value;
        logic            taken;
        logic [XLEN-1:0] next_pc;
    } ex_res_t;

    typedef struct packed {
        logic            en;
        logic [4:0]      addr;
        logic [XLEN-1:0] data;
    } rf_wr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            write_rd;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] rd_value;
        logic [XLEN-1:0] next_pc;
    } retire_t;

endpackage

// ==== reg_file.sv ====
// ----------------------------------------
// integer register file, 2 read 1 write
// ----------------------------------------
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  rf_wr_t          wr_i
);

    logic [XLEN-1:0] regs [31:1]; // no storage behind x0

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_i.en && wr_i.addr != 5'd0)
        begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

endmodule

// ==== decode.sv ====
// ----------------------------------------
// decode stage: fields, immediates, control,
// operand forwarding and id/ex register
// ----------------------------------------
`timescale 1ns/1ps

module decode
    import rv_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  fetch_t          fetch_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  rf_wr_t          fwd_ex_i,  // result of the instruction in execute
    input  rf_wr_t          fwd_wb_i,  // value being written this cycle
    output id_ex_t          id_ex_o
);

    instr_u          instr;
    opcode_t         opcode;
    logic [2:0]      func3;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0] curr_imm;
    logic [XLEN-1:0] rs1_fwd, rs2_fwd;
    alu_oper_t       alu_oper;
    alu_oper1_src_t  alu_oper1_src;
    alu_oper2_src_t  alu_oper2_src;
    bnj_oper_t       bnj_oper;
    logic            write_rd;

    // execute result first, then write-back, then the register file
    function automatic logic [XLEN-1:0] fwd_sel(input logic [4:0] addr,
                                                 input logic [XLEN-1:0] rf_data,
                                                 input rf_wr_t ex,
                                                 input rf_wr_t wb);
        logic [XLEN-1:0] val;
        val = rf_data;
        if (addr != 5'd0)
        begin
            if (ex.en && ex.addr == addr)
                val = ex.data;
            else if (wb.en && wb.addr == addr)
                val = wb.data;
        end
        return val;
    endfunction

    assign instr.raw = fetch_i.instr;
    assign opcode    = opcode_t'(instr.r.opcode);
    assign func3     = instr.r.func3;

    assign rs1_addr_o = instr.r.rs1;
    assign rs2_addr_o = instr.r.rs2;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    assign rs1_fwd = fwd_sel(rs1_addr_o, rs1_data_i, fwd_ex_i, fwd_wb_i);
    assign rs2_fwd = fwd_sel(rs2_addr_o, rs2_data_i, fwd_ex_i, fwd_wb_i);

    always_comb
    begin : main_decode
        alu_oper1_src = OPER1_RS1;
        alu_oper2_src = OPER2_RS2;
        curr_imm      = '0;
        write_rd      = 1'b0;
        bnj_oper      = BNJ_NO;
        case (opcode)
            LUI:
            begin
                alu_oper1_src = OPER1_ZERO;
                alu_oper2_src = OPER2_IMM;
                curr_imm      = imm_u;
                write_rd      = 1'b1;
            end
            AUIPC:
            begin
                alu_oper1_src = OPER1_PC;
                alu_oper2_src = OPER2_IMM;
                curr_imm      = imm_u;
                write_rd      = 1'b1;
            end
            JAL, JALR:
            begin
                alu_oper1_src = OPER1_PC;     // link = pc + 4
                alu_oper2_src = OPER2_PC_INC;
                curr_imm      = (opcode == JAL) ? imm_j : imm_i;
                write_rd      = 1'b1;
                bnj_oper      = (opcode == JAL) ? BNJ_JAL : BNJ_JALR;
            end
            BRANCH:
            begin
                curr_imm = imm_b;
                bnj_oper = BNJ_BRANCH;
            end
            LOAD:      curr_imm = imm_i; // retires as no-op
            STORE:     curr_imm = imm_s;
            ARITH:     write_rd = 1'b1;
            ARITH_IMM:
            begin
                alu_oper2_src = OPER2_IMM;
                curr_imm      = imm_i;
                write_rd      = 1'b1;
            end
            default: ; // unknown opcode, no-op
        endcase
    end

    always_comb
    begin : alu_decode
        alu_oper = ALU_ADD;
        case (opcode)
            BRANCH:
            begin
                if (opcode_branch_t'(func3) == BEQ)
                    alu_oper = ALU_SEQ;
                else if (opcode_branch_t'(func3) == BNE)
                    alu_oper = ALU_SUB; // nonzero when different
                else
                    alu_oper = alu_oper_t'({func3[0], 1'b0, func3[2:1]});
            end
            ARITH:     alu_oper = alu_oper_t'({instr.r.func7[5], func3});
            ARITH_IMM:
            begin
                // bit 30 only selects sra for the immediate form
                if (opcode_alu_t'(func3) == SRA_L)
                    alu_oper = alu_oper_t'({instr.r.func7[5], func3});
                else
                    alu_oper = alu_oper_t'({1'b0, func3});
            end
            default:   alu_oper = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin : id_ex_reg
        if (!rstn_i)
        begin
            id_ex_o <= '0;
        end
        else
        begin
            id_ex_o.valid         <= fetch_i.valid;
            id_ex_o.pc            <= fetch_i.pc;
            id_ex_o.rs1_data      <= rs1_fwd;
            id_ex_o.rs2_data      <= rs2_fwd;
            id_ex_o.imm           <= curr_imm;
            id_ex_o.alu_oper      <= alu_oper;
            id_ex_o.alu_oper1_src <= alu_oper1_src;
            id_ex_o.alu_oper2_src <= alu_oper2_src;
            id_ex_o.bnj_oper      <= bnj_oper;
            id_ex_o.write_rd      <= write_rd;
            id_ex_o.rd_addr       <= instr.r.rd;
        end
    end

endmodule

// ==== execute.sv ====
// ----------------------------------------
// execute stage: alu, branch/jump resolve
// ----------------------------------------
`timescale 1ns/1ps

module execute
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
)
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  id_ex_t  id_ex_i,
    output rf_wr_t  fwd_ex_o,
    output ex_res_t ex_res_o
);

    logic [XLEN-1:0] oper1, oper2, alu_res;
    logic [XLEN-1:0] pc_inc, target, next_pc;
    logic [4:0]      shamt;
    logic            taken;

    assign shamt  = oper2[4:0];
    assign pc_inc = id_ex_i.pc + XLEN'(4);
    // jalr adds to rs1, jal and branches to pc
    assign target = ((id_ex_i.bnj_oper == BNJ_JALR) ? id_ex_i.rs1_data : id_ex_i.pc)
                    + id_ex_i.imm;

    always_comb
    begin
        case (id_ex_i.alu_oper1_src)
            OPER1_RS1: oper1 = id_ex_i.rs1_data;
            OPER1_PC:  oper1 = id_ex_i.pc;
            default:   oper1 = '0;
        endcase
        case (id_ex_i.alu_oper2_src)
            OPER2_RS2: oper2 = id_ex_i.rs2_data;
            OPER2_IMM: oper2 = id_ex_i.imm;
            default:   oper2 = XLEN'(4);
        endcase
    end

    always_comb
    begin : alu
        case (id_ex_i.alu_oper)
            ALU_ADD:               alu_res = oper1 + oper2;
            ALU_SUB:               alu_res = oper1 - oper2;
            ALU_SLL:               alu_res = oper1 << shamt;
            ALU_SLT, ALU_SLT_N:    alu_res = XLEN'($signed(oper1) < $signed(oper2));
            ALU_SLTU, ALU_SLTU_N:  alu_res = XLEN'(oper1 < oper2);
            ALU_XOR:               alu_res = oper1 ^ oper2;
            ALU_SRL:               alu_res = oper1 >> shamt;
            ALU_SRA:               alu_res = $signed(oper1) >>> shamt;
            ALU_OR:                alu_res = oper1 | oper2;
            ALU_AND:               alu_res = oper1 & oper2;
            ALU_SEQ:               alu_res = XLEN'(oper1 == oper2);
            default:               alu_res = '0;
        endcase
    end

    always_comb
    begin : bnj
        taken   = 1'b0;
        next_pc = pc_inc;
        case (id_ex_i.bnj_oper)
            BNJ_JAL:
            begin
                taken   = 1'b1;
                next_pc = target;
            end
            BNJ_JALR:
            begin
                taken   = 1'b1;
                next_pc = {target[XLEN-1:1], 1'b0};
            end
            BNJ_BRANCH:
            begin
                // bge/bgeu take the inverted compare
                taken = (alu_res != '0) ^ (id_ex_i.alu_oper inside {ALU_SLT_N, ALU_SLTU_N});
                if (taken)
                    next_pc = target;
            end
            default: ;
        endcase
    end

    assign fwd_ex_o.en   = id_ex_i.valid && id_ex_i.write_rd;
    assign fwd_ex_o.addr = id_ex_i.rd_addr;
    assign fwd_ex_o.data = alu_res;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin : ex_res_reg
        if (!rstn_i)
        begin
            ex_res_o         <= '0;
            ex_res_o.pc      <= RESET_PC;
            ex_res_o.next_pc <= RESET_PC;
        end
        else
        begin
            ex_res_o.valid    <= id_ex_i.valid;
            ex_res_o.pc       <= id_ex_i.pc;
            ex_res_o.write_rd <= id_ex_i.write_rd;
            ex_res_o.rd_addr  <= id_ex_i.rd_addr;
            ex_res_o.rd_value <= alu_res;
            ex_res_o.taken    <= taken;
            ex_res_o.next_pc  <= next_pc;
        end
    end

endmodule

// ==== result.sv ====
// ----------------------------------------
// result stage: rf write and retire report
// ----------------------------------------
`timescale 1ns/1ps

module result
    import rv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  ex_res_t ex_res_i,
    output rf_wr_t  rf_wr_o,
    output retire_t retire_o
);

    logic wr_en;
    logic ret_en;

    assign ret_en = ex_res_i.valid;
    // x0 writes retire but never land
    assign wr_en  = ret_en && ex_res_i.write_rd && (ex_res_i.rd_addr != 5'd0);

    assign rf_wr_o.en   = wr_en;
    assign rf_wr_o.addr = ex_res_i.rd_addr;
    assign rf_wr_o.data = ex_res_i.rd_value;

    assign retire_o.valid    = ret_en; // one cycle per instruction
    assign retire_o.pc       = ex_res_i.pc;
    assign retire_o.write_rd = wr_en;
    assign retire_o.rd_addr  = ex_res_i.rd_addr;
    assign retire_o.rd_value = ex_res_i.rd_value;
    assign retire_o.next_pc  = ex_res_i.next_pc;

endmodule

// ==== rv_core_top.sv ====
// ----------------------------------------
// rv32i integer core top level
// ----------------------------------------
`timescale 1ns/1ps

module rv_core_top
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
)
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  fetch_t  fetch_i,
    output retire_t retire_o
);

    logic [4:0]      rs1_addr, rs2_addr;
    logic [XLEN-1:0] rs1_data, rs2_data;
    rf_wr_t          fwd_ex;
    rf_wr_t          rf_wr;   // also the write-back forward
    id_ex_t          id_ex;
    ex_res_t         ex_res;

    decode u_decode (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .fetch_i    (fetch_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fwd_ex_i   (fwd_ex),
        .fwd_wb_i   (rf_wr),
        .id_ex_o    (id_ex)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (rf_wr)
    );

    execute #(
        .RESET_PC (RESET_PC)
    ) u_execute (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .id_ex_i  (id_ex),
        .fwd_ex_o (fwd_ex),
        .ex_res_o (ex_res)
    );

    result u_result (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ex_res_i (ex_res),
        .rf_wr_o  (rf_wr),
        .retire_o (retire_o)
    );

endmodule

// ==== tb_rv_core.sv ====
// ----------------------------------------
// testbench for rv_core_top: stimulus table,
// retire checker and timeout
// ----------------------------------------
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 5;
    localparam int LATENCY      = 2; // retire cycle after the strobe cycle

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;

    logic    clk_i;
    logic    rstn_i;
    fetch_t  fetch_i;
    retire_t retire_o;

    // stimulus and expected-value table
    string       t_name[$];
    logic [31:0] t_instr[$];
    logic [31:0] t_pc[$];
    logic        t_wr[$];
    logic [4:0]  t_rd[$];
    logic [31:0] t_val[$];
    logic [31:0] t_npc[$];
    bit          t_gap[$];

    int pend_idx[$]; // entries strobed but not yet retired
    int pend_cyc[$];

    logic [31:0] cur_pc;
    bit          allow_gap;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          n_gaps = 0;
    int          limit = 1000000;

    rv_core_top dut0 (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .fetch_i  (fetch_i),
        .retire_o (retire_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
        cycles <= cycles + 1;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] instr, input logic wr,
                             input logic [4:0] rd, input logic [31:0] val,
                             input logic [31:0] npc);
        bit gap;
        gap = allow_gap && ($urandom % 4 == 0);
        t_name.push_back(name);
        t_instr.push_back(instr);
        t_pc.push_back(cur_pc);
        t_wr.push_back(wr);
        t_rd.push_back(rd);
        t_val.push_back(val);
        t_npc.push_back(npc);
        t_gap.push_back(gap);
        if (gap)
            n_gaps++;
        cur_pc = cur_pc + 32'd4;
    endtask

    // sequential instruction, next pc is pc + 4
    task automatic add_op(input string name, input logic [31:0] instr, input logic wr,
                          input logic [4:0] rd, input logic [31:0] val);
        add_entry(name, instr, wr, rd, val, cur_pc + 32'd4);
    endtask

    task automatic add_branch(input string name, input logic [31:0] instr,
                              input logic [31:0] npc);
        add_entry(name, instr, 1'b0, 5'd0, 32'd0, npc);
    endtask

    task automatic build_table();
        cur_pc    = 32'h0000_1000;
        allow_gap = 1'b1;
        add_op("lui",      u_type(OP_LUI, 5'd1, 20'h12345), 1, 5'd1, 32'h1234_5000);
        add_op("auipc",    u_type(OP_AUIPC, 5'd2, 20'h00001), 1, 5'd2, cur_pc + 32'h1000);
        add_op("addi_neg", i_type(OP_IMM, 3'b000, 5'd3, 5'd0, -12'd5), 1, 5'd3, 32'hffff_fffb);
        add_op("addi",     i_type(OP_IMM, 3'b000, 5'd4, 5'd1, 12'h678), 1, 5'd4, 32'h1234_5678);
        add_op("slti",     i_type(OP_IMM, 3'b010, 5'd5, 5'd3, -12'd4), 1, 5'd5, 32'h1);
        add_op("sltiu",    i_type(OP_IMM, 3'b011, 5'd6, 5'd3, 12'd5), 1, 5'd6, 32'h0);
        add_op("xori",     i_type(OP_IMM, 3'b100, 5'd7, 5'd4, 12'h0ff), 1, 5'd7, 32'h1234_5687);
        add_op("ori",      i_type(OP_IMM, 3'b110, 5'd8, 5'd0, 12'h0f0), 1, 5'd8, 32'h0000_00f0);
        add_op("andi",     i_type(OP_IMM, 3'b111, 5'd9, 5'd4, 12'h0f0), 1, 5'd9, 32'h0000_0070);
        add_op("slli",     i_type(OP_IMM, 3'b001, 5'd10, 5'd4, 12'h004), 1, 5'd10, 32'h2345_6780);
        add_op("srli",     i_type(OP_IMM, 3'b101, 5'd11, 5'd3, 12'h01c), 1, 5'd11, 32'h0000_000f);
        add_op("srai",     i_type(OP_IMM, 3'b101, 5'd12, 5'd3, 12'h401), 1, 5'd12, 32'hffff_fffd);
        add_op("add",  r_type(7'h00, 3'b000, 5'd13, 5'd4, 5'd3), 1, 5'd13, 32'h1234_5673);
        add_op("sub",  r_type(7'h20, 3'b000, 5'd14, 5'd3, 5'd4), 1, 5'd14, 32'hedcb_a983);
        add_op("slt",  r_type(7'h00, 3'b010, 5'd15, 5'd3, 5'd8), 1, 5'd15, 32'h1);
        add_op("sltu", r_type(7'h00, 3'b011, 5'd16, 5'd3, 5'd8), 1, 5'd16, 32'h0);
        add_op("xor",  r_type(7'h00, 3'b100, 5'd17, 5'd4, 5'd8), 1, 5'd17, 32'h1234_5688);
        add_op("or",   r_type(7'h00, 3'b110, 5'd18, 5'd8, 5'd9), 1, 5'd18, 32'h0000_00f0);
        add_op("and",  r_type(7'h00, 3'b111, 5'd19, 5'd4, 5'd3), 1, 5'd19, 32'h1234_5678);
        add_op("sll",  r_type(7'h00, 3'b001, 5'd20, 5'd4, 5'd11), 1, 5'd20, 32'h2b3c_0000);
        add_op("srl",  r_type(7'h00, 3'b101, 5'd21, 5'd3, 5'd11), 1, 5'd21, 32'h0001_ffff);
        add_op("sra",  r_type(7'h20, 3'b101, 5'd22, 5'd3, 5'd11), 1, 5'd22, 32'hffff_ffff);
        allow_gap = 1'b0; // back to back, both forwarding paths
        add_op("chain_1", i_type(OP_IMM, 3'b000, 5'd23, 5'd0, 12'd1), 1, 5'd23, 32'd1);
        add_op("chain_2", i_type(OP_IMM, 3'b000, 5'd24, 5'd23, 12'd2), 1, 5'd24, 32'd3);
        add_op("chain_3", r_type(7'h00, 3'b000, 5'd25, 5'd24, 5'd23), 1, 5'd25, 32'd4);
        add_op("chain_4", r_type(7'h00, 3'b000, 5'd26, 5'd25, 5'd24), 1, 5'd26, 32'd7);
        add_op("chain_5", r_type(7'h20, 3'b000, 5'd27, 5'd26, 5'd25), 1, 5'd27, 32'd3);
        add_op("chain_6", i_type(OP_IMM, 3'b001, 5'd27, 5'd27, 12'd2), 1, 5'd27, 32'd12);
        add_op("chain_7", r_type(7'h00, 3'b000, 5'd28, 5'd27, 5'd26), 1, 5'd28, 32'd19);
        allow_gap = 1'b1;
        // x3 = -5, x8 = 0xf0
        add_branch("beq_t",  b_type(3'b000, 5'd3, 5'd3, 13'h010), cur_pc + 32'h10);
        add_branch("beq_n",  b_type(3'b000, 5'd3, 5'd8, 13'h010), cur_pc + 32'd4);
        add_branch("bne_t",  b_type(3'b001, 5'd3, 5'd8, -13'd8), cur_pc - 32'd8);
        add_branch("bne_n",  b_type(3'b001, 5'd8, 5'd8, 13'h010), cur_pc + 32'd4);
        add_branch("blt_t",  b_type(3'b100, 5'd3, 5'd8, 13'h020), cur_pc + 32'h20);
        add_branch("blt_n",  b_type(3'b100, 5'd8, 5'd3, 13'h020), cur_pc + 32'd4);
        add_branch("bge_t",  b_type(3'b101, 5'd8, 5'd3, -13'd16), cur_pc - 32'd16);
        add_branch("bge_n",  b_type(3'b101, 5'd3, 5'd8, 13'h020), cur_pc + 32'd4);
        add_branch("bge_eq", b_type(3'b101, 5'd3, 5'd3, 13'h008), cur_pc + 32'd8);
        add_branch("bltu_t", b_type(3'b110, 5'd8, 5'd3, 13'h040), cur_pc + 32'h40);
        add_branch("bltu_n", b_type(3'b110, 5'd3, 5'd8, 13'h040), cur_pc + 32'd4);
        add_branch("bgeu_t", b_type(3'b111, 5'd3, 5'd8, 13'h100), cur_pc + 32'h100);
        add_branch("bgeu_n", b_type(3'b111, 5'd8, 5'd3, 13'h100), cur_pc + 32'd4);
        add_entry("jal_fwd",  j_type(5'd1, 21'h000200), 1, 5'd1, cur_pc + 32'd4,
                  cur_pc + 32'h200);
        add_entry("jal_back", j_type(5'd29, -21'd64), 1, 5'd29, cur_pc + 32'd4,
                  cur_pc - 32'd64);
        add_entry("jalr_odd", i_type(OP_JALR, 3'b000, 5'd30, 5'd4, 12'h011), 1, 5'd30,
                  cur_pc + 32'd4, 32'h1234_5688);
        add_entry("jalr_neg", i_type(OP_JALR, 3'b000, 5'd31, 5'd3, 12'h008), 1, 5'd31,
                  cur_pc + 32'd4, 32'h0000_0002);
        add_op("x0_write", i_type(OP_IMM, 3'b000, 5'd0, 5'd4, 12'd1), 0, 5'd0, 32'd0);
        add_op("x0_read",  i_type(OP_IMM, 3'b000, 5'd7, 5'd0, 12'd3), 1, 5'd7, 32'd3);
        add_op("x0_add",   r_type(7'h00, 3'b000, 5'd5, 5'd0, 5'd0), 1, 5'd5, 32'd0);
        add_op("load",     i_type(OP_LOAD, 3'b010, 5'd9, 5'd1, 12'd4), 0, 5'd0, 32'd0);
        add_op("load_chk", i_type(OP_IMM, 3'b000, 5'd10, 5'd9, 12'd0), 1, 5'd10, 32'h70);
        add_op("store",    i_type(OP_STORE, 3'b010, 5'd12, 5'd4, 12'd0), 0, 5'd0, 32'd0);
        add_op("unknown",  32'hffff_ffff, 0, 5'd0, 32'd0);
        add_op("all_zero", 32'h0000_0000, 0, 5'd0, 32'd0);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_retire();
        int    idx;
        int    issued;
        string name;
        if (pend_idx.size() == 0)
        begin
            $display("ERROR: retire strobe at pc %h with nothing pending", retire_o.pc);
            other_errors++;
        end
        else
        begin
            idx    = pend_idx.pop_front();
            issued = pend_cyc.pop_front();
            name   = t_name[idx];
            compare_field(name, "latency", issued + LATENCY, cycles);
            compare_field(name, "pc", t_pc[idx], retire_o.pc);
            compare_field(name, "write_rd", 32'(t_wr[idx]), 32'(retire_o.write_rd));
            if (t_wr[idx])
            begin
                compare_field(name, "rd_addr", 32'(t_rd[idx]), 32'(retire_o.rd_addr));
                compare_field(name, "rd_value", t_val[idx], retire_o.rd_value);
            end
            compare_field(name, "next_pc", t_npc[idx], retire_o.next_pc);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i)
    begin
        if (retire_o.valid)
            check_retire();
    end

    always @(negedge clk_i)
    begin
        if (cycles >= limit)
        begin
            $display("ERROR: run timed out after %0d cycles", cycles);
            other_errors++;
            foreach (pend_idx[k])
                $display("ERROR: %s never retired", t_name[pend_idx[k]]);
            other_errors += pend_idx.size();
            finish_run();
        end
    end

    initial
    begin
        fetch_i  = '0;
        rstn_i   = 1'b0;
        void'($urandom(32'hbba0));
        build_table();
        limit = RESET_CYCLES + IDLE_CYCLES + t_instr.size() + n_gaps + 20;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (IDLE_CYCLES) @(negedge clk_i); // no strobe may appear here
        for (int i = 0; i < t_instr.size(); i++)
        begin
            if (t_gap[i])
            begin
                fetch_i.valid = 1'b0;
                @(negedge clk_i);
            end
            fetch_i.valid = 1'b1;
            fetch_i.instr = t_instr[i];
            fetch_i.pc    = t_pc[i];
            pend_idx.push_back(i);
            pend_cyc.push_back(cycles);
            @(negedge clk_i);
        end
        fetch_i = '0;
        while (pend_idx.size() != 0)
            @(negedge clk_i);
        repeat (4) @(negedge clk_i); // catch stray strobes
        finish_run();
    end

endmodule

// ==== build.f ====
rv_pkg.sv
reg_file.sv
decode.sv
execute.sv
result.sv
rv_core_top.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - reg_file.sv
  - decode.sv
  - execute.sv
  - result.sv
  - rv_core_top.sv
  - target: test
    files:
      - tb_rv_core.sv
